/* rename.f */
+incdir+include
hw/rename_pkg.sv
hw/rob_pkg.sv
hw/free_list.sv
hw/rename_lane.sv
hw/rename_map.sv
hw/rob_queue.sv
hw/rename_top.sv
testbench/rename_tb.sv

/* Makefile */
TOP = rename_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rename.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/rename_tb_model.svh */
`ifndef RENAME_TB_MODEL_SVH
`define RENAME_TB_MODEL_SVH

  // reference state for the rename stage
  rename_pkg::phys_reg_t map_ref [rename_pkg::NUM_ARCH_REGS];
  rename_pkg::phys_reg_t free_q [$];  // oldest free reg at the front
  rob_pkg::rob_entry_t   exp_q [$];   // entries in accept order

  task automatic init_model();
    free_q.delete();
    exp_q.delete();
    for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
      map_ref[r] = rename_pkg::phys_reg_t'(r);
    end
    for (int p = rename_pkg::NUM_ARCH_REGS; p < rename_pkg::NUM_PHYS_REGS; p++) begin
      free_q.push_back(rename_pkg::phys_reg_t'(p));
    end
  endtask

  // two regs free and room for a whole group
  function automatic logic expected_in_ready();
    return (free_q.size() >= rename_pkg::GROUP_WIDTH) &&
           (exp_q.size() <= rob_pkg::ROB_DEPTH - rename_pkg::GROUP_WIDTH);
  endfunction

  // lanes one after the other, map updated in between
  task automatic rename_expected(input rename_pkg::uop_group_t grp);
    rob_pkg::rob_entry_t   e;
    rename_pkg::arch_reg_t src1;
    for (int i = 0; i < rename_pkg::GROUP_WIDTH; i++) begin
      e        = '0;
      e.opcode = grp[i].opcode;
      e.kind   = grp[i].kind;
      e.dest   = grp[i].dest;
      if (grp[i].kind == rename_pkg::UOP_RI) begin
        src1        = grp[i].payload.ri.src1;
        e.src2_phys = '0;
        e.imm       = grp[i].payload.ri.imm;
      end else begin
        src1        = grp[i].payload.rr.src1;
        e.src2_phys = map_ref[grp[i].payload.rr.src2];
        e.imm       = '0;
      end
      e.src1_phys = map_ref[src1];  // read before own dest write
      e.old_phys  = map_ref[grp[i].dest];
      e.new_phys  = free_q.pop_front();
      map_ref[grp[i].dest] = e.new_phys;
      exp_q.push_back(e);
    end
  endtask

`endif

/* testbench/rename_tb.sv */
`default_nettype none

module rename_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD     = 10;
  localparam int NUM_GROUPS     = 400;
  localparam int TIMEOUT_CYCLES = 20 * NUM_GROUPS;

  logic                   clk;
  logic                   rst_N_in;
  logic                   in_valid;
  rename_pkg::uop_group_t in_group;
  logic                   in_ready;
  logic                   commit_valid;
  rob_pkg::rob_entry_t    commit_entry;
  logic                   commit_ready;

  integer seed = 52827;
  int     accepted;
  int     cycle;
  int     stall_cycles;  // in_valid high but held back
  logic   accept_hs;
  logic   commit_hs;

  rename_top dut (
    .clk          (clk),
    .rst_N_in     (rst_N_in),
    .in_valid     (in_valid),
    .in_group     (in_group),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit_entry (commit_entry),
    .commit_ready (commit_ready)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  `include "rename_tb_model.svh"

  function automatic rename_pkg::uop_t random_uop();
    rename_pkg::uop_t u;
    u.opcode  = 8'($random(seed));
    u.kind    = rename_pkg::uop_kind_e'(1'($random(seed)));
    u.dest    = rename_pkg::arch_reg_t'($random(seed));
    u.payload = 16'($random(seed));  // spare bits random too
    return u;
  endfunction

  task automatic expect_commit(input rob_pkg::rob_entry_t got);
    rob_pkg::rob_entry_t want;
    want = exp_q.pop_front();
    check_value("commit_entry.opcode", 32'(got.opcode), 32'(want.opcode));
    check_value("commit_entry.kind", 32'(got.kind), 32'(want.kind));
    check_value("commit_entry.dest", 32'(got.dest), 32'(want.dest));
    check_value("commit_entry.new_phys", 32'(got.new_phys), 32'(want.new_phys));
    check_value("commit_entry.old_phys", 32'(got.old_phys), 32'(want.old_phys));
    check_value("commit_entry.src1_phys", 32'(got.src1_phys), 32'(want.src1_phys));
    check_value("commit_entry.src2_phys", 32'(got.src2_phys), 32'(want.src2_phys));
    check_value("commit_entry.imm", 32'(got.imm), 32'(want.imm));
    free_q.push_back(want.old_phys);  // rejoins at the tail
  endtask

  task automatic drive_inputs();
    rename_pkg::uop_group_t grp;
    if (accepted >= NUM_GROUPS) begin
      in_valid     = 1'b0;
      commit_ready = 1'b1;  // drain
    end else begin
      if (accepted < 120) commit_ready = (($random(seed) & 3) != 0);
      else if (accepted < 240) commit_ready = ((cycle % 40) >= 30);  // long low stretches
      else commit_ready = (($random(seed) & 1) != 0);
      if (accept_hs || !in_valid) begin
        grp[0] = random_uop();
        grp[1] = random_uop();
        // same-group dependencies on lane 0's dest
        if (($random(seed) & 3) == 0) grp[1].dest = grp[0].dest;
        if (($random(seed) & 3) == 0) grp[1].payload.rr.src1 = grp[0].dest;
        if (($random(seed) & 3) == 0) grp[1].payload.rr.src2 = grp[0].dest;
        in_group = grp;
        in_valid = (($random(seed) & 3) != 0);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial begin
    rst_N_in     = 1'b0;
    in_valid     = 1'b0;
    in_group     = '0;
    commit_ready = 1'b0;
    accepted     = 0;
    cycle        = 0;
    stall_cycles = 0;
    accept_hs    = 1'b0;
    commit_hs    = 1'b0;
    init_model();
    repeat (4) @(posedge clk);
    #1 rst_N_in = 1'b1;

    while (accepted < NUM_GROUPS || exp_q.size() != 0) begin
      @(negedge clk);  // outputs settled, handshakes happen at next edge
      check_value("in_ready", 32'(in_ready), 32'(expected_in_ready()));
      check_value("commit_valid", 32'(commit_valid), 32'(exp_q.size() != 0));
      accept_hs = in_valid && in_ready;
      commit_hs = commit_valid && commit_ready;
      if (in_valid && !in_ready) stall_cycles++;
      if (commit_hs) expect_commit(commit_entry);
      if (accept_hs) begin
        rename_expected(in_group);
        accepted++;
      end
      @(posedge clk);
      #1;
      cycle++;
      drive_inputs();
    end

    @(negedge clk);
    check_value("commit_valid", 32'(commit_valid), 32'(0));
    if (stall_cycles == 0) begin
      $display("in_ready never held a group back, the reorder buffer never filled");
      $display("TESTS FAILED");
      $fatal(1);
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hw/rename_top.sv */
`default_nettype none

module rename_top (
  input  logic                   clk,
  input  logic                   rst_N_in,
  input  logic                   in_valid,
  input  rename_pkg::uop_group_t in_group,
  output logic                   in_ready,
  output logic                   commit_valid,
  output rob_pkg::rob_entry_t    commit_entry,
  input  logic                   commit_ready
);

  rename_pkg::phys_reg_t [rename_pkg::GROUP_WIDTH-1:0] alloc_regs;
  logic                                                alloc_ok;
  logic                                                alloc_take;
  logic                                                accept;
  logic                                                rob_space_ok;
  logic                                                release_valid;
  rename_pkg::phys_reg_t                               release_reg;
  rob_pkg::rob_group_t                                 rob_group;

  assign in_ready = alloc_ok && rob_space_ok;  // independent of in_valid
  assign accept   = in_valid && in_ready;

  free_list u_free_list (
    .clk           (clk),
    .rst_N_in      (rst_N_in),
    .alloc_take    (alloc_take),
    .alloc_regs    (alloc_regs),
    .alloc_ok      (alloc_ok),
    .release_valid (release_valid),
    .release_reg   (release_reg)
  );

  rename_map u_rename_map (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .in_valid   (in_valid),
    .in_group   (in_group),
    .alloc_regs (alloc_regs),
    .accept     (accept),
    .alloc_take (alloc_take),
    .rob_group  (rob_group)
  );

  rob_queue u_rob_queue (
    .clk           (clk),
    .rst_N_in      (rst_N_in),
    .write_en      (alloc_take),
    .write_group   (rob_group),
    .rob_space_ok  (rob_space_ok),
    .commit_valid  (commit_valid),
    .commit_entry  (commit_entry),
    .commit_ready  (commit_ready),
    .release_valid (release_valid),
    .release_reg   (release_reg)
  );

endmodule

`default_nettype wire

/* hw/rob_queue.sv */
`default_nettype none

module rob_queue (
  input  logic                  clk,
  input  logic                  rst_N_in,
  input  logic                  write_en,
  input  rob_pkg::rob_group_t   write_group,
  output logic                  rob_space_ok,
  output logic                  commit_valid,
  output rob_pkg::rob_entry_t   commit_entry,
  input  logic                  commit_ready,
  output logic                  release_valid,
  output rename_pkg::phys_reg_t release_reg
);

  rob_pkg::rob_entry_t rob_mem [rob_pkg::ROB_DEPTH];
  rob_pkg::rob_idx_t   head;
  rob_pkg::rob_idx_t   tail;
  rob_pkg::rob_cnt_t   count;

  // room for a whole group
  assign rob_space_ok =
    (count <= rob_pkg::rob_cnt_t'(rob_pkg::ROB_DEPTH - rename_pkg::GROUP_WIDTH));

  assign commit_valid  = (count != '0);
  assign commit_entry  = rob_mem[head];
  assign release_valid = commit_valid && commit_ready;  // retire handshake
  assign release_reg   = rob_mem[head].old_phys;

  // entry storage
  always_ff @(posedge clk) begin
    if (write_en) begin
      for (int k = 0; k < rename_pkg::GROUP_WIDTH; k++) begin
        rob_mem[tail + rob_pkg::rob_idx_t'(k)] <= write_group[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (write_en) begin
        tail <= tail + rob_pkg::rob_idx_t'(rename_pkg::GROUP_WIDTH);
      end
      if (release_valid) begin
        head <= head + 1'b1;
      end
      count <= count
             + (write_en ? rob_pkg::rob_cnt_t'(rename_pkg::GROUP_WIDTH) : '0)
             - rob_pkg::rob_cnt_t'(release_valid);
    end
  end

  // in_ready at the top must have held the group back
  a_write_with_space: assert property (
    @(posedge clk) disable iff (!rst_N_in) write_en |-> rob_space_ok
  );

  // occupancy must match the pointer distance, so empty means head on tail
  a_count_matches_ptrs: assert property (
    @(posedge clk) disable iff (!rst_N_in)
      tail == head + rob_pkg::rob_idx_t'(count)
  );

endmodule

`default_nettype wire

/* hw/rename_map.sv */
`default_nettype none

module rename_map (
  input  logic                                                clk,
  input  logic                                                rst_N_in,
  input  logic                                                in_valid,
  input  rename_pkg::uop_group_t                              in_group,
  input  rename_pkg::phys_reg_t [rename_pkg::GROUP_WIDTH-1:0] alloc_regs,
  input  logic                                                accept,
  output logic                                                alloc_take,
  output rob_pkg::rob_group_t                                 rob_group
);

  rename_pkg::phys_reg_t                                map_table [rename_pkg::NUM_ARCH_REGS];
  rename_pkg::map_write_t [rename_pkg::GROUP_WIDTH-1:0] lane_writes;

  assign alloc_take = accept;  // accept already includes in_ready

  for (genvar g = 0; g < rename_pkg::GROUP_WIDTH; g++) begin : g_lane
    rename_pkg::map_write_t [rename_pkg::GROUP_WIDTH-1:0] older;
    rename_pkg::phys_reg_t                                rd_src1;
    rename_pkg::phys_reg_t                                rd_src2;
    rename_pkg::phys_reg_t                                rd_dest;

    // src1 sits at the same bits in both payload views
    assign rd_src1 = map_table[in_group[g].payload.rr.src1];
    assign rd_src2 = map_table[in_group[g].payload.rr.src2];  // ignored by reg-imm lanes
    assign rd_dest = map_table[in_group[g].dest];

    // lane g only sees writes from lanes below it
    always_comb begin
      for (int k = 0; k < rename_pkg::GROUP_WIDTH; k++) begin
        older[k] = lane_writes[k];
        if (k >= g) older[k].valid = 1'b0;
      end
    end

    rename_lane u_lane (
      .uop          (in_group[g]),
      .map_src1     (rd_src1),
      .map_src2     (rd_src2),
      .map_dest     (rd_dest),
      .new_reg      (alloc_regs[g]),
      .older_writes (older),
      .entry        (rob_group[g]),
      .lane_write   (lane_writes[g])
    );
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
        map_table[r] <= rename_pkg::phys_reg_t'(r);  // identity
      end
    end else if (accept) begin
      // lane order, so a younger lane to the same dest lands last
      for (int k = 0; k < rename_pkg::GROUP_WIDTH; k++) begin
        if (lane_writes[k].valid) begin
          map_table[lane_writes[k].arch] <= lane_writes[k].phys;
        end
      end
    end
  end

  // a waiting group must not change under us
  a_group_stable: assert property (
    @(posedge clk) disable iff (!rst_N_in)
      (in_valid && !accept) ##1 in_valid |-> $stable(in_group)
  );

endmodule

`default_nettype wire

/* hw/rename_lane.sv */
`default_nettype none

module rename_lane (
  input  rename_pkg::uop_t                                     uop,
  input  rename_pkg::phys_reg_t                                map_src1,
  input  rename_pkg::phys_reg_t                                map_src2,
  input  rename_pkg::phys_reg_t                                map_dest,
  input  rename_pkg::phys_reg_t                                new_reg,
  input  rename_pkg::map_write_t [rename_pkg::GROUP_WIDTH-1:0] older_writes,
  output rob_pkg::rob_entry_t                                  entry,
  output rename_pkg::map_write_t                               lane_write
);

  rename_pkg::uop_rr_t   rr_view;
  rename_pkg::uop_ri_t   ri_view;
  logic                  is_ri;
  rename_pkg::arch_reg_t src1_arch;
  rename_pkg::phys_reg_t src1_phys;
  rename_pkg::phys_reg_t src2_phys;
  rename_pkg::phys_reg_t old_phys;

  assign rr_view   = uop.payload.rr;
  assign ri_view   = uop.payload.ri;
  assign is_ri     = (uop.kind == rename_pkg::UOP_RI);
  assign src1_arch = rr_view.src1;  // same bits in both views

  // bypass from older lanes, higher index is younger and wins
  always_comb begin
    src1_phys = map_src1;
    src2_phys = map_src2;
    old_phys  = map_dest;
    for (int k = 0; k < rename_pkg::GROUP_WIDTH; k++) begin
      if (older_writes[k].valid) begin
        if (older_writes[k].arch == src1_arch) src1_phys = older_writes[k].phys;
        if (older_writes[k].arch == rr_view.src2) src2_phys = older_writes[k].phys;
        if (older_writes[k].arch == uop.dest) old_phys = older_writes[k].phys;
      end
    end
    if (is_ri) src2_phys = '0;  // no second source
  end

  always_comb begin
    entry.opcode    = uop.opcode;
    entry.kind      = uop.kind;
    entry.dest      = uop.dest;
    entry.new_phys  = new_reg;
    entry.old_phys  = old_phys;
    entry.src1_phys = src1_phys;
    entry.src2_phys = src2_phys;
    entry.imm       = is_ri ? ri_view.imm : '0;
  end

  // every uop writes a dest
  assign lane_write.valid = 1'b1;
  assign lane_write.arch  = uop.dest;
  assign lane_write.phys  = new_reg;

endmodule

`default_nettype wire

/* hw/free_list.sv */
`default_nettype none

module free_list (
  input  logic                                                clk,
  input  logic                                                rst_N_in,
  input  logic                                                alloc_take,
  output rename_pkg::phys_reg_t [rename_pkg::GROUP_WIDTH-1:0] alloc_regs,
  output logic                                                alloc_ok,
  input  logic                                                release_valid,
  input  rename_pkg::phys_reg_t                               release_reg
);

  rename_pkg::phys_reg_t fifo_mem [rename_pkg::NUM_FREE_REGS];
  rename_pkg::free_idx_t head;
  rename_pkg::free_idx_t tail;
  rename_pkg::free_cnt_t count;

  // oldest free regs first, lane 0 gets the head
  always_comb begin
    for (int k = 0; k < rename_pkg::GROUP_WIDTH; k++) begin
      alloc_regs[k] = fifo_mem[head + rename_pkg::free_idx_t'(k)];
    end
  end

  assign alloc_ok = (count >= rename_pkg::free_cnt_t'(rename_pkg::GROUP_WIDTH));

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      // everything above the identity map starts out free
      for (int i = 0; i < rename_pkg::NUM_FREE_REGS; i++) begin
        fifo_mem[i] <= rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH_REGS + i);
      end
      head  <= '0;
      tail  <= '0;  // queue full, tail wraps onto head
      count <= rename_pkg::free_cnt_t'(rename_pkg::NUM_FREE_REGS);
    end else begin
      if (release_valid) begin
        fifo_mem[tail] <= release_reg;  // released regs join at the tail
        tail           <= tail + 1'b1;
      end
      if (alloc_take) begin
        head <= head + rename_pkg::free_idx_t'(rename_pkg::GROUP_WIDTH);
      end
      count <= count
             + rename_pkg::free_cnt_t'(release_valid)
             - (alloc_take ? rename_pkg::free_cnt_t'(rename_pkg::GROUP_WIDTH) : '0);
    end
  end

  // the map side must only take when two regs are there
  a_take_with_regs: assert property (
    @(posedge clk) disable iff (!rst_N_in) alloc_take |-> alloc_ok
  );

  // a double release from the rob would push past the pool size
  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_N_in)
      count <= rename_pkg::free_cnt_t'(rename_pkg::NUM_FREE_REGS)
  );

endmodule

`default_nettype wire

/* hw/rob_pkg.sv */
`default_nettype none

package rob_pkg;

  localparam int ROB_DEPTH = 16;

  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
  typedef logic [$clog2(ROB_DEPTH):0]   rob_cnt_t;  // occupancy, 0..ROB_DEPTH

  typedef struct packed {
    rename_pkg::opcode_t   opcode;
    rename_pkg::uop_kind_e kind;
    rename_pkg::arch_reg_t dest;
    rename_pkg::phys_reg_t new_phys;   // freshly allocated dest
    rename_pkg::phys_reg_t old_phys;   // previous mapping, freed at commit
    rename_pkg::phys_reg_t src1_phys;
    rename_pkg::phys_reg_t src2_phys;  // zero for reg-imm
    rename_pkg::imm_t      imm;        // zero for reg-reg
  } rob_entry_t;

  typedef rob_entry_t [rename_pkg::GROUP_WIDTH-1:0] rob_group_t;

endpackage

`default_nettype wire

/* hw/rename_pkg.sv */
`default_nettype none

package rename_pkg;

  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_PHYS_REGS = 48;
  localparam int GROUP_WIDTH   = 2;   // uops renamed per cycle
  // registers not mapped at reset, all sitting in the free queue
  localparam int NUM_FREE_REGS = NUM_PHYS_REGS - NUM_ARCH_REGS;

  typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;
  typedef logic [7:0]                       opcode_t;
  typedef logic [10:0]                      imm_t;

  typedef logic [$clog2(NUM_FREE_REGS)-1:0] free_idx_t;
  typedef logic [$clog2(NUM_FREE_REGS):0]   free_cnt_t;  // holds 0..NUM_FREE_REGS

  typedef enum logic {
    UOP_RR = 1'b0,  // two register sources
    UOP_RI = 1'b1   // one source plus immediate
  } uop_kind_e;

  typedef struct packed {
    arch_reg_t  src1;
    arch_reg_t  src2;
    logic [5:0] spare;
  } uop_rr_t;

  typedef struct packed {
    arch_reg_t src1;
    imm_t      imm;
  } uop_ri_t;

  // same 16 bits, read according to kind
  typedef union packed {
    uop_rr_t rr;
    uop_ri_t ri;
  } uop_payload_u;

  typedef struct packed {
    opcode_t      opcode;
    uop_kind_e    kind;
    arch_reg_t    dest;
    uop_payload_u payload;
  } uop_t;

  typedef uop_t [GROUP_WIDTH-1:0] uop_group_t;

  // one lane's update to the map table
  typedef struct packed {
    logic      valid;
    arch_reg_t arch;
    phys_reg_t phys;
  } map_write_t;

endpackage

`default_nettype wire
